/* bench/tb_tlb_model.svh */
// Reference model of the translation buffer, included in the testbench module
// Tracks ways and victim pointers per set and queues the expected responses
`ifndef TB_TLB_MODEL_SVH
`define TB_TLB_MODEL_SVH

bit       m_valid [NUM_SETS][NUM_WAYS];
tag_t     m_tag   [NUM_SETS][NUM_WAYS];
pa_page_t m_pa    [NUM_SETS][NUM_WAYS];
int       m_ptr   [NUM_SETS];

// Expected responses in issue order, with the cycle each one is due
va_page_t exp_va    [$];
bit       exp_hit   [$];
pa_page_t exp_pa    [$];
int       exp_cycle [$];

// Empties every set and restarts every pointer at way 0
function automatic void empty_model();
    for (int s = 0; s < NUM_SETS; s++)
    begin
        m_ptr[s] = 0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            m_valid[s][w] = 1'b0;
        end
    end
endfunction

// The low page bits select the set, the rest is the tag
function automatic int set_of(va_page_t va);
    return int'(va[SET_IDX_BITS-1:0]);
endfunction

function automatic void insert_translation(va_page_t va, pa_page_t pa);
    int s;
    int way;
    s   = set_of(va);
    way = -1;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
        if (way < 0 && !m_valid[s][w])
        begin
            way = w;
        end
    end
    // A full set gives up the way under its pointer, which then moves on
    if (way < 0)
    begin
        way      = m_ptr[s];
        m_ptr[s] = (m_ptr[s] + 1) % NUM_WAYS;
    end
    m_valid[s][way] = 1'b1;
    m_tag[s][way]   = va[VA_PAGE_BITS-1:SET_IDX_BITS];
    m_pa[s][way]    = pa;
endfunction

function automatic void forget_set(va_page_t va);
    for (int w = 0; w < NUM_WAYS; w++)
    begin
        m_valid[set_of(va)][w] = 1'b0;
    end
endfunction

// Lowest matching way wins; the response is due LOOKUP_LATENCY after acceptance
function automatic void queue_response(va_page_t va, int accept_cycle);
    int       s;
    bit       hit;
    pa_page_t pa;
    s   = set_of(va);
    hit = 1'b0;
    pa  = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
        if (!hit && m_valid[s][w] && m_tag[s][w] == va[VA_PAGE_BITS-1:SET_IDX_BITS])
        begin
            hit = 1'b1;
            pa  = m_pa[s][w];
        end
    end
    exp_va.push_back(va);
    exp_hit.push_back(hit);
    exp_pa.push_back(pa);
    exp_cycle.push_back(accept_cycle + LOOKUP_LATENCY);
endfunction

`endif

/* bench/tb_vtp_tlb.sv */
// Testbench of the translation buffer
// Random fills, lookups, invalidations and clears checked against a model
`timescale 1ns/1ps
`default_nettype none

module tb_vtp_tlb;

    import tlb_addr_pkg::*;
    import tlb_entry_pkg::*;

    localparam int WAIT_LIMIT = 64;
    localparam int EVICT_SET  = 9;

    logic     clk = 1'b0;
    logic     reset;
    logic     lookup_en;
    va_page_t lookup_va;
    logic     lookup_rdy;
    logic     rsp_valid;
    logic     rsp_miss;
    pa_page_t rsp_pa;
    va_page_t rsp_va;
    logic     fill_en;
    va_page_t fill_va;
    pa_page_t fill_pa;
    logic     fill_rdy;
    logic     inval_en;
    va_page_t inval_va;
    logic     clear;

    int seed     = 29;
    int cycle    = 0;
    int n_tests  = 0;
    int n_checks = 0;
    int n_errors = 0;

    // Few sets on purpose so fills collide and evict
    int       set_pool [3] = '{3, 7, 12};
    va_page_t filled_va [$];
    va_page_t evict_va  [$];

    `include "tb_tlb_model.svh"

    vtp_tlb i_vtp_tlb
    (
        .clk        (clk),
        .reset      (reset),
        .lookup_en  (lookup_en),
        .lookup_va  (lookup_va),
        .lookup_rdy (lookup_rdy),
        .rsp_valid  (rsp_valid),
        .rsp_miss   (rsp_miss),
        .rsp_pa     (rsp_pa),
        .rsp_va     (rsp_va),
        .fill_en    (fill_en),
        .fill_va    (fill_va),
        .fill_pa    (fill_pa),
        .fill_rdy   (fill_rdy),
        .inval_en   (inval_en),
        .inval_va   (inval_va),
        .clear      (clear)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    // ============================================================
    // Checking helpers
    // ============================================================

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        n_checks++;
        if (expected !== actual)
        begin
            $display("error at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
            n_errors++;
        end
    endtask

    task automatic report_failure(string what);
        $display("failure at %0t ns: %s", $time, what);
        n_errors++;
    endtask

    task automatic finish_test(string name);
        n_tests++;
        $display("test %0d (%s) finished, errors so far: %0d", n_tests, name, n_errors);
    endtask

    // Responses are sampled on the falling edge, away from the register updates
    always @(negedge clk)
    begin
        if (!reset && (rsp_valid || rsp_miss))
        begin
            if (rsp_valid && rsp_miss)
            begin
                report_failure("rsp_valid and rsp_miss were high together");
            end
            if (exp_va.size() == 0)
            begin
                report_failure("a response arrived with no lookup outstanding");
            end
            else
            begin
                compare_value("response cycle", exp_cycle.pop_front(), cycle);
                compare_value("rsp_valid", exp_hit[0], rsp_valid);
                compare_value("rsp_miss", !exp_hit[0], rsp_miss);
                compare_value("rsp_va", exp_va.pop_front(), rsp_va);
                if (exp_hit.pop_front())
                begin
                    compare_value("rsp_pa", exp_pa[0], rsp_pa);
                end
                void'(exp_pa.pop_front());
            end
        end
    end

    // ============================================================
    // Stimulus helpers
    // ============================================================

    function automatic va_page_t random_va(int set);
        tag_t tag;
        tag = tag_t'($random(seed));
        return {tag, set_idx_t'(set)};
    endfunction

    function automatic int pool_set();
        return set_pool[$unsigned($random(seed)) % 3];
    endfunction

    // Waits until both ports are ready and every lookup has answered
    task automatic wait_idle();
        bit idle;
        idle = 1'b0;
        for (int w = 0; w < WAIT_LIMIT; w++)
        begin
            @(negedge clk);
            if (fill_rdy && lookup_rdy && exp_va.size() == 0)
            begin
                idle = 1'b1;
                break;
            end
        end
        if (!idle)
        begin
            report_failure("the DUT did not return to idle in time");
        end
    endtask

    // One lookup per cycle, back to back
    task automatic issue_lookups(input va_page_t vas[$]);
        foreach (vas[i])
        begin
            @(posedge clk);
            #1;
            lookup_en = 1'b1;
            lookup_va = vas[i];
            queue_response(vas[i], cycle + 1);
        end
        @(posedge clk);
        #1;
        lookup_en = 1'b0;
        wait_idle();
    endtask

    // Presents a fill for one cycle, or until it is taken when hold is set
    task automatic offer_fill(input va_page_t va, input pa_page_t pa, input bit hold,
                              output bit taken);
        taken = 1'b0;
        @(posedge clk);
        #1;
        fill_en = 1'b1;
        fill_va = va;
        fill_pa = pa;
        for (int w = 0; w < WAIT_LIMIT; w++)
        begin
            @(negedge clk);
            // The model takes the fill only on the handshake edge
            if (fill_rdy)
            begin
                insert_translation(va, pa);
                taken = 1'b1;
            end
            @(posedge clk);
            #1;
            if (taken || !hold)
            begin
                break;
            end
        end
        fill_en = 1'b0;
        if (hold && !taken)
        begin
            report_failure("a held fill was never accepted by the DUT");
        end
    endtask

    // Fills two pages more than a set has ways so that two ways are evicted in turn
    task automatic fill_full_set();
        tag_t     base;
        va_page_t va;
        bit       taken;
        base = tag_t'($random(seed));
        evict_va.delete();
        for (int i = 0; i < NUM_WAYS + 2; i++)
        begin
            va = {tag_t'(base + i), set_idx_t'(EVICT_SET)};
            wait_idle();
            offer_fill(va, pa_page_t'($random(seed)), 1'b1, taken);
            evict_va.push_back(va);
        end
        wait_idle();
    endtask

    task automatic invalidate_set(input va_page_t va);
        wait_idle();
        @(posedge clk);
        #1;
        inval_en = 1'b1;
        inval_va = va;
        forget_set(va);
        @(posedge clk);
        #1;
        inval_en = 1'b0;
        // The set is rewritten one cycle after the pulse, so reads wait past that
        repeat (2) @(posedge clk);
    endtask

    task automatic run_clear();
        int low_cycles;
        bit fell;
        wait_idle();
        @(posedge clk);
        #1;
        clear = 1'b1;
        empty_model();
        @(posedge clk);
        #1;
        clear = 1'b0;
        fell = 1'b0;
        for (int w = 0; w < WAIT_LIMIT; w++)
        begin
            @(negedge clk);
            if (!lookup_rdy)
            begin
                fell = 1'b1;
                break;
            end
        end
        if (!fell)
        begin
            report_failure("lookup_rdy never dropped after the clear pulse");
        end
        else
        begin
            // The walk covers one set per cycle
            low_cycles = 1;
            for (int w = 0; w < WAIT_LIMIT; w++)
            begin
                @(negedge clk);
                if (lookup_rdy)
                begin
                    break;
                end
                low_cycles++;
            end
            compare_value("lookup_rdy low cycles", NUM_SETS, low_cycles);
        end
        wait_idle();
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        va_page_t vas [$];
        va_page_t va_a;
        va_page_t va_b;
        va_page_t va_c;
        bit       taken;

        reset     = 1'b1;
        lookup_en = 1'b0;
        lookup_va = '0;
        fill_en   = 1'b0;
        fill_va   = '0;
        fill_pa   = '0;
        inval_en  = 1'b0;
        inval_va  = '0;
        clear     = 1'b0;
        empty_model();
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_idle();

        // An empty buffer misses everywhere
        for (int i = 0; i < 8; i++)
        begin
            vas.push_back(random_va($unsigned($random(seed)) % NUM_SETS));
        end
        issue_lookups(vas);
        finish_test("misses after reset");

        for (int i = 0; i < 6; i++)
        begin
            filled_va.push_back(random_va(pool_set()));
            wait_idle();
            offer_fill(filled_va[i], pa_page_t'($random(seed)), 1'b1, taken);
        end
        wait_idle();
        vas.delete();
        for (int i = 0; i < 6; i++)
        begin
            vas.push_back(filled_va[i]);
            vas.push_back(random_va(pool_set()));
        end
        issue_lookups(vas);
        finish_test("fill then hit");

        fill_full_set();
        issue_lookups(evict_va);
        finish_test("round-robin eviction");

        invalidate_set(evict_va[2]);
        vas = evict_va;
        foreach (filled_va[i])
        begin
            vas.push_back(filled_va[i]);
        end
        issue_lookups(vas);
        finish_test("set invalidation");

        run_clear();
        issue_lookups(filled_va);
        fill_full_set();
        issue_lookups(evict_va);
        finish_test("full clear");

        // A second fill arrives during the bubble and must be dropped
        va_a = random_va(12);
        va_b = random_va(5);
        va_c = random_va(12);
        wait_idle();
        offer_fill(va_a, pa_page_t'($random(seed)), 1'b1, taken);
        offer_fill(va_b, pa_page_t'($random(seed)), 1'b0, taken);
        if (taken)
        begin
            report_failure("fill_rdy was high during the bubble of the previous fill");
        end
        offer_fill(va_c, pa_page_t'($random(seed)), 1'b1, taken);
        wait_idle();
        vas.delete();
        vas.push_back(va_a);
        vas.push_back(va_b);
        vas.push_back(va_c);
        issue_lookups(vas);
        finish_test("fill while busy");

        if (n_checks == 0)
        begin
            report_failure("no response was ever checked");
        end
        $display("tests: %0d, checks: %0d, errors: %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/tlb_addr_pkg.sv */
// Address geometry shared by the translation buffer and its testbench
// A virtual page index splits into a tag (high bits) and a set index (low bits)
`default_nettype none

package tlb_addr_pkg;

    // Page index widths, one fixed page size
    localparam int VA_PAGE_BITS = 20;
    localparam int PA_PAGE_BITS = 16;

    // Sets are direct mapped by the low virtual page bits
    localparam int NUM_SETS     = 16;
    localparam int SET_IDX_BITS = 4;
    localparam int TAG_BITS     = VA_PAGE_BITS - SET_IDX_BITS;

    typedef logic [VA_PAGE_BITS-1:0] va_page_t;
    typedef logic [PA_PAGE_BITS-1:0] pa_page_t;
    typedef logic [SET_IDX_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0]     tag_t;

    // Set that a virtual page maps to
    function automatic set_idx_t va_set(va_page_t va);
        return va[SET_IDX_BITS-1:0];
    endfunction

    // Tag stored alongside the entry to tell pages of one set apart
    function automatic tag_t va_tag(va_page_t va);
        return va[VA_PAGE_BITS-1:SET_IDX_BITS];
    endfunction

endpackage

`default_nettype wire

/* common/tlb_entry_pkg.sv */
// Storage and sequencing definitions of the translation buffer
// Entry layout, associativity, pipeline depth and fill FSM states
`default_nettype none

package tlb_entry_pkg;

    // Associativity of each set
    localparam int NUM_WAYS     = 4;
    localparam int WAY_IDX_BITS = 2;

    // One stored translation, 33 bits wide
    // The valid bit sits lowest so an all-zero word is an empty way
    typedef struct packed
    {
        tlb_addr_pkg::tag_t     tag;
        tlb_addr_pkg::pa_page_t pa;
        logic                   valid;
    } tlb_entry_t;

    // Cycles from an accepted lookup to its response
    localparam int LOOKUP_LATENCY = 6;

    // Idle cycles after a fill write before the next fill is taken
    localparam int FILL_BUBBLE_CYCLES = 8;

    // Fill FSM
    typedef enum logic [1:0]
    {
        UPD_IDLE,
        UPD_INSERT,
        UPD_BUBBLE
    } update_state_t;

endpackage

`default_nettype wire

/* tlb/tlb_lookup.sv */
// Pipelined lookup of a virtual page in all ways of its set
// One request per cycle; hit with the PA or miss with the VA after six cycles
`timescale 1ns/1ps
`default_nettype none

module tlb_lookup
(
    input  wire logic                       clk,
    input  wire logic                       reset,

    input  wire logic                       lookup_en,
    input  wire tlb_addr_pkg::va_page_t     lookup_va,

    output tlb_addr_pkg::set_idx_t          raddr,
    input  wire tlb_entry_pkg::tlb_entry_t  rdata [tlb_entry_pkg::NUM_WAYS],

    output logic                            rsp_valid,
    output logic                            rsp_miss,
    output tlb_addr_pkg::pa_page_t          rsp_pa,
    output tlb_addr_pkg::va_page_t          rsp_va
);

    import tlb_addr_pkg::*;
    import tlb_entry_pkg::*;

    // ============================================================
    // Request state carried alongside the data path
    // ============================================================

    // Index s holds the request registered s cycles after acceptance
    logic     req_valid [0:LOOKUP_LATENCY-2];
    va_page_t req_va    [0:LOOKUP_LATENCY-1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 0; s < LOOKUP_LATENCY - 1; s++)
            begin
                req_valid[s] <= 1'b0;
            end
        end
        else
        begin
            req_valid[0] <= lookup_en;
            for (int s = 1; s < LOOKUP_LATENCY - 1; s++)
            begin
                req_valid[s] <= req_valid[s-1];
            end
        end

        req_va[0] <= lookup_va;
        for (int s = 1; s < LOOKUP_LATENCY; s++)
        begin
            req_va[s] <= req_va[s-1];
        end
    end

    // Stage 0 addresses the ways from the registered request
    // and stage 1 waits while the RAM read completes
    assign raddr = va_set(req_va[0]);

    // ============================================================
    // Stage 2: per-way tag XOR, first half of the compare
    // ============================================================

    tag_t              s3_xor   [NUM_WAYS];
    logic [NUM_WAYS-1:0] s3_valid;
    pa_page_t          s3_pa    [NUM_WAYS];

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            s3_xor[w]   <= rdata[w].tag ^ va_tag(req_va[2]);
            s3_valid[w] <= rdata[w].valid;
            s3_pa[w]    <= rdata[w].pa;
        end
    end

    // ============================================================
    // Stage 3: reduce the XOR to one match bit per way
    // ============================================================

    logic [NUM_WAYS-1:0] s4_match;
    pa_page_t            s4_pa [NUM_WAYS];

    always_ff @(posedge clk)
    begin
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            // A way matches only when every tag bit agreed and it holds data
            s4_match[w] <= s3_valid[w] && !(|s3_xor[w]);
            s4_pa[w]    <= s3_pa[w];
        end
    end

    // ============================================================
    // Stage 4: pick the lowest matching way
    // ============================================================

    logic                    s4_hit;
    logic [WAY_IDX_BITS-1:0] s4_way;

    always_comb
    begin
        s4_hit = |s4_match;
        s4_way = '0;
        // Walk downwards so the lowest matching way is the one kept
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (s4_match[w])
            begin
                s4_way = WAY_IDX_BITS'(w);
            end
        end
    end

    logic     s5_hit;
    logic     s5_miss;
    pa_page_t s5_pa;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s5_hit  <= 1'b0;
            s5_miss <= 1'b0;
        end
        else
        begin
            s5_hit  <= req_valid[4] && s4_hit;
            s5_miss <= req_valid[4] && !s4_hit;
        end
        s5_pa <= s4_pa[s4_way];
    end

    // ============================================================
    // Stage 5: response registers
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
            rsp_miss  <= 1'b0;
        end
        else
        begin
            rsp_valid <= s5_hit;
            rsp_miss  <= s5_miss;
        end
        rsp_pa <= s5_pa;
        rsp_va <= req_va[5];
    end

    // Every accepted lookup ends in exactly one of hit or miss, on time
    a_one_response : assert property (@(posedge clk) disable iff (reset)
        lookup_en |=> ##LOOKUP_LATENCY (rsp_valid ^ rsp_miss));

endmodule

`default_nettype wire

/* tlb/tlb_update.sv */
// Write side of the translation buffer
// Inserts fills with first-invalid or round-robin victim choice, handles
// set invalidation and sequences the full clear of the way memories
`timescale 1ns/1ps
`default_nettype none

module tlb_update
(
    input  wire logic                              clk,
    input  wire logic                              reset,

    input  wire logic                              fill_en,
    input  wire tlb_addr_pkg::va_page_t            fill_va,
    input  wire tlb_addr_pkg::pa_page_t            fill_pa,
    output logic                                   fill_rdy,

    input  wire logic                              inval_en,
    input  wire tlb_addr_pkg::va_page_t            inval_va,
    input  wire logic                              clear,

    input  wire logic                              ram_rdy,

    output tlb_addr_pkg::set_idx_t                 waddr,
    output tlb_entry_pkg::tlb_entry_t              wdata,
    output logic [tlb_entry_pkg::NUM_WAYS-1:0]     wen,
    output logic                                   ram_clear
);

    import tlb_addr_pkg::*;
    import tlb_entry_pkg::*;

    update_state_t state;
    logic [$clog2(FILL_BUBBLE_CYCLES)-1:0] bubble_cnt;

    // Latched fill request
    tag_t     fill_tag_q;
    set_idx_t fill_set_q;
    pa_page_t fill_pa_q;

    // Shadow of the valid bits so the victim is known without a read
    logic [NUM_WAYS-1:0]     set_valid [NUM_SETS];
    logic [WAY_IDX_BITS-1:0] rr_ptr    [NUM_SETS];

    logic                    clr_d1;
    logic                    write_ok;
    logic                    fill_take;
    logic                    fill_write;
    logic                    inval_write;
    logic                    set_full;
    logic [WAY_IDX_BITS-1:0] victim;

    // ============================================================
    // Clear sequencing and write arbitration
    // ============================================================

    // Clear reaches the memories two cycles later; reset holds it high
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clr_d1    <= 1'b1;
            ram_clear <= 1'b1;
        end
        else
        begin
            clr_d1    <= clear;
            ram_clear <= clr_d1;
        end
    end

    // No writes from the moment a clear is pending until the walk ends
    assign write_ok    = ram_rdy && !clr_d1 && !ram_clear;
    assign fill_rdy    = (state == UPD_IDLE) && write_ok && !clear;
    assign fill_take   = fill_en && fill_rdy;
    assign inval_write = inval_en && write_ok;

    // Invalidation and clear both win over a fill in the same cycle
    assign fill_write  = (state == UPD_INSERT) && !inval_write && !clear;

    // Victim is the first empty way, otherwise the set's pointer
    always_comb
    begin
        set_full = &set_valid[fill_set_q];
        victim   = rr_ptr[fill_set_q];
        for (int w = NUM_WAYS - 1; w >= 0; w--)
        begin
            if (!set_valid[fill_set_q][w])
            begin
                victim = WAY_IDX_BITS'(w);
            end
        end
    end

    // ============================================================
    // Fill FSM
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= UPD_IDLE;
            bubble_cnt <= '0;
        end
        else
        begin
            case (state)
                UPD_IDLE:
                begin
                    if (fill_take)
                    begin
                        state <= UPD_INSERT;
                    end
                end
                UPD_INSERT:
                begin
                    state      <= UPD_BUBBLE;
                    bubble_cnt <= ($clog2(FILL_BUBBLE_CYCLES))'(FILL_BUBBLE_CYCLES - 1);
                end
                UPD_BUBBLE:
                begin
                    if (bubble_cnt == '0)
                    begin
                        state <= UPD_IDLE;
                    end
                    else
                    begin
                        bubble_cnt <= bubble_cnt - 1'b1;
                    end
                end
                default:
                begin
                    state <= UPD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_take)
        begin
            fill_tag_q <= va_tag(fill_va);
            fill_set_q <= va_set(fill_va);
            fill_pa_q  <= fill_pa;
        end
    end

    // ============================================================
    // Registered write port towards all ways
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wen <= '0;
        end
        else if (inval_write)
        begin
            wen <= '1;
        end
        else
        begin
            wen <= '0;
            if (fill_write)
            begin
                wen[victim] <= 1'b1;
            end
        end

        // Invalidation writes an empty entry to every way of the set
        if (inval_write)
        begin
            waddr <= va_set(inval_va);
            wdata <= '0;
        end
        else
        begin
            waddr <= fill_set_q;
            wdata <= '{tag: fill_tag_q, pa: fill_pa_q, valid: 1'b1};
        end
    end

    // Valid shadow and pointers follow exactly the writes issued above
    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                set_valid[s] <= '0;
                rr_ptr[s]    <= '0;
            end
        end
        else if (inval_write)
        begin
            set_valid[va_set(inval_va)] <= '0;
        end
        else if (fill_write)
        begin
            set_valid[fill_set_q][victim] <= 1'b1;
            // Only an eviction from a full set moves the pointer on
            if (set_full)
            begin
                rr_ptr[fill_set_q] <= rr_ptr[fill_set_q] + 1'b1;
            end
        end
    end

    // A taken fill keeps the port closed through insert and the whole bubble
    a_fill_busy : assert property (@(posedge clk) disable iff (reset)
        fill_take |=> !fill_rdy [*FILL_BUBBLE_CYCLES + 1]);

endmodule

`default_nettype wire

/* tlb/tlb_way_ram.sv */
// One way of translation storage, one entry per set
// Two-cycle registered read; reset or clear walks every set to invalid
`timescale 1ns/1ps
`default_nettype none

module tlb_way_ram
(
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       clear,
    output logic                            rdy,

    input  wire tlb_addr_pkg::set_idx_t     waddr,
    input  wire logic                       wen,
    input  wire tlb_entry_pkg::tlb_entry_t  wdata,

    input  wire tlb_addr_pkg::set_idx_t     raddr,
    output tlb_entry_pkg::tlb_entry_t       rdata
);

    import tlb_addr_pkg::*;
    import tlb_entry_pkg::*;

    tlb_entry_t mem [NUM_SETS];
    tlb_entry_t rd_q;

    // Walk state, one set written per cycle
    logic     walking;
    set_idx_t walk_addr;

    assign rdy = !walking;

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            walking   <= 1'b1;
            walk_addr <= '0;
        end
        else if (walking)
        begin
            walk_addr <= walk_addr + 1'b1;
            // Last set written this cycle, storage usable from the next
            if (walk_addr == set_idx_t'(NUM_SETS - 1))
            begin
                walking <= 1'b0;
            end
        end
    end

    // Single write port shared by the walk and normal updates
    always_ff @(posedge clk)
    begin
        if (walking)
        begin
            mem[walk_addr] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Array read then output register, data two edges after the address
    always_ff @(posedge clk)
    begin
        rd_q  <= mem[raddr];
        rdata <= rd_q;
    end

    // The updater must hold off writes while the walk owns the port
    a_no_write_in_walk : assert property (@(posedge clk) disable iff (reset) wen |-> rdy);

endmodule

`default_nettype wire

/* verilog/vtp_tlb.sv */
// Top level of the set-associative translation buffer
// Connects the way memories to the lookup pipeline and the update logic
`timescale 1ns/1ps
`default_nettype none

module vtp_tlb
(
    input  wire logic                    clk,
    input  wire logic                    reset,

    input  wire logic                    lookup_en,
    input  wire tlb_addr_pkg::va_page_t  lookup_va,
    output logic                         lookup_rdy,
    output logic                         rsp_valid,
    output logic                         rsp_miss,
    output tlb_addr_pkg::pa_page_t       rsp_pa,
    output tlb_addr_pkg::va_page_t       rsp_va,

    input  wire logic                    fill_en,
    input  wire tlb_addr_pkg::va_page_t  fill_va,
    input  wire tlb_addr_pkg::pa_page_t  fill_pa,
    output logic                         fill_rdy,

    input  wire logic                    inval_en,
    input  wire tlb_addr_pkg::va_page_t  inval_va,
    input  wire logic                    clear
);

    import tlb_addr_pkg::*;
    import tlb_entry_pkg::*;

    // Address and write data are broadcast to every way
    set_idx_t            raddr;
    set_idx_t            waddr;
    tlb_entry_t          wdata;
    logic [NUM_WAYS-1:0] way_wen;
    logic [NUM_WAYS-1:0] way_rdy;
    tlb_entry_t          way_rdata [NUM_WAYS];
    logic                ram_clear;

    // All ways walk in lockstep, so way 0 speaks for lookups
    assign lookup_rdy = way_rdy[0];

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : gen_way
        tlb_way_ram i_way_ram
        (
            .clk   (clk),
            .reset (reset),
            .clear (ram_clear),
            .rdy   (way_rdy[w]),
            .waddr (waddr),
            .wen   (way_wen[w]),
            .wdata (wdata),
            .raddr (raddr),
            .rdata (way_rdata[w])
        );
    end

    tlb_lookup i_lookup
    (
        .clk       (clk),
        .reset     (reset),
        .lookup_en (lookup_en),
        .lookup_va (lookup_va),
        .raddr     (raddr),
        .rdata     (way_rdata),
        .rsp_valid (rsp_valid),
        .rsp_miss  (rsp_miss),
        .rsp_pa    (rsp_pa),
        .rsp_va    (rsp_va)
    );

    tlb_update i_update
    (
        .clk       (clk),
        .reset     (reset),
        .fill_en   (fill_en),
        .fill_va   (fill_va),
        .fill_pa   (fill_pa),
        .fill_rdy  (fill_rdy),
        .inval_en  (inval_en),
        .inval_va  (inval_va),
        .clear     (clear),
        .ram_rdy   (&way_rdy),
        .waddr     (waddr),
        .wdata     (wdata),
        .wen       (way_wen),
        .ram_clear (ram_clear)
    );

endmodule

`default_nettype wire

/* vtp_tlb.f */
+incdir+bench
common/tlb_addr_pkg.sv
common/tlb_entry_pkg.sv
tlb/tlb_way_ram.sv
tlb/tlb_lookup.sv
tlb/tlb_update.sv
verilog/vtp_tlb.sv
bench/tb_vtp_tlb.sv
